// ==== bench/tb_clk_gen.sv ====
/* Testbench clock and power-on reset */
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic reset_o
);

	// Period of 4 time units
	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// Reset held for the first 10 rising edges, released just after the edge
	initial begin
		reset_o = 1'b1;
		repeat (10) @(posedge clk_o);
		#1 reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/tb_vp_cart_sys.sv ====
/* Testbench for the cartridge and timing block, with memory, mapping
   and classification models, random download and read traffic */
`default_nettype none
`include "vp_cart_cfg.svh"

module tb_vp_cart_sys;

	localparam int NUM_READS   = 300;
	localparam int TOTAL_BYTES = 2048 + 4096 + 8192 + 16384 + 4096 + 4096;
	// Worst case about 12 cycles per stalled byte, plus reads and the enable runs
	localparam int LIMIT_CYCLES = TOTAL_BYTES * 12 + 8 * NUM_READS * 4 + 2000;

	logic        clk_sys;
	logic        reset;
	logic        pal_i;
	logic        download_i;
	logic [7:0]  index_i;
	logic        psel_i;
	logic        penable_i;
	logic        pwrite_i;
	logic [13:0] paddr_i;
	logic [7:0]  pwdata_i;
	logic        pready_o;
	logic        pslverr_o;
	logic        cart_rd_i;
	logic [11:0] cart_a_i;
	logic        cart_bs0_i;
	logic        cart_bs1_i;
	logic [7:0]  cart_d_o;
	logic        rd_valid_o;
	logic        cpu_en_o;
	logic        vdc_en_o;

	integer                  seed;
	int                      err_cnt;
	int                      check_cnt;
	int                      store_cnt;
	logic                    dl_seen;
	logic                    dl_busy;
	logic [7:0]              model_mem [16384];
	vp_cart_pkg::cart_kind_e kind_model;

	tb_clk_gen clk_gen_i (
		.clk_o   (clk_sys),
		.reset_o (reset)
	);

	vp_cart_sys dut_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_i      (pal_i),
		.download_i (download_i),
		.index_i    (index_i),
		.psel_i     (psel_i),
		.penable_i  (penable_i),
		.pwrite_i   (pwrite_i),
		.paddr_i    (paddr_i),
		.pwdata_i   (pwdata_i),
		.pready_o   (pready_o),
		.pslverr_o  (pslverr_o),
		.cart_rd_i  (cart_rd_i),
		.cart_a_i   (cart_a_i),
		.cart_bs0_i (cart_bs0_i),
		.cart_bs1_i (cart_bs1_i),
		.cart_d_o   (cart_d_o),
		.rd_valid_o (rd_valid_o),
		.cpu_en_o   (cpu_en_o),
		.vdc_en_o   (vdc_en_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Models
	////////////////////////////////////////////////////////////////////////////

	// Kind from image size, XROM index first
	function automatic vp_cart_pkg::cart_kind_e classify(input int size, input bit xrom);
		if (xrom)
			return vp_cart_pkg::CART_XROM;
		else if (size == 4096)
			return vp_cart_pkg::CART_4K;
		else if (size == 8192)
			return vp_cart_pkg::CART_8K;
		else if (size == 16384)
			return vp_cart_pkg::CART_12K;
		return vp_cart_pkg::CART_2K;
	endfunction

	// Console address and bank bits to memory address
	function automatic logic [13:0] map_addr(input vp_cart_pkg::cart_kind_e kind,
			input logic [11:0] a, input logic b0, input logic b1);
		logic [13:0] m;
		case (kind)
			vp_cart_pkg::CART_XROM: m = {2'b00, a};
			vp_cart_pkg::CART_4K:   m = {2'b00, b0, a[11], a[9:0]};
			vp_cart_pkg::CART_8K:   m = {1'b0, b1, b0, a[11], a[9:0]};
			vp_cart_pkg::CART_12K:  m = {b1, b0, a};
			default:                m = {3'b000, a[11], a[9:0]};
		endcase
		return m;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks and monitors
	////////////////////////////////////////////////////////////////////////////

	task automatic check(input logic [31:0] exp_val, input logic [31:0] act_val,
			input string msg);
		check_cnt++;
		if (act_val !== exp_val) begin
			err_cnt++;
			$display("Fail at %0t: %s, expected %0h, got %0h", $time, msg, exp_val, act_val);
		end
	endtask

	// Download level as sampled by the last edge
	always @(posedge clk_sys)
		dl_seen <= download_i;

	// Memory write count, enables frozen during download
	always @(negedge clk_sys) begin
		if (dut_i.mem_we === 1'b1)
			store_cnt++;
		if (dl_seen)
			check(32'd0, 32'({cpu_en_o, vdc_en_o}), "clock enable during download");
	end

	initial begin
		#(LIMIT_CYCLES * 4);
		$display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks, all entered and left 1 unit after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic write, input logic [13:0] addr,
			input logic [7:0] data, output logic err, output int waits);
		logic done;
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = write;
		paddr_i = addr;
		pwdata_i = data;
		@(posedge clk_sys);
		#1;
		penable_i = 1'b1;
		waits = 0;
		done = 1'b0;
		// Stays in access phase until the slave is ready
		while (done !== 1'b1) begin
			@(negedge clk_sys);
			done = pready_o;
			err = pslverr_o;
			waits++;
			@(posedge clk_sys);
			#1;
		end
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	// One console read, data checked one cycle later
	task automatic issue_read(input logic [11:0] a, input logic b0, input logic b1);
		cart_rd_i = 1'b1;
		cart_a_i = a;
		cart_bs0_i = b0;
		cart_bs1_i = b1;
		@(negedge clk_sys);
		check(32'd0, 32'(pready_o), "pready while console reads");
		@(posedge clk_sys);
		#1;
		check(32'd1, 32'(rd_valid_o), "read valid");
		check(32'(model_mem[map_addr(kind_model, a, b0, b1)]), 32'(cart_d_o), "read data");
	endtask

	task automatic random_read();
		logic [11:0] a;
		logic        b0;
		logic        b1;
		a = 12'($random(seed));
		b0 = 1'($random(seed));
		b1 = 1'($random(seed));
		issue_read(a, b0, b1);
	endtask

	task automatic run_reads(input int n);
		for (int k = 0; k < n; k++)
			random_read();
		cart_rd_i = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	// Read bursts with idle gaps while the download runs
	task automatic stall_reads();
		int gap;
		int len;
		while (dl_busy) begin
			gap = 1 + {$random(seed)} % 4;
			repeat (gap) begin
				@(posedge clk_sys);
				#1;
			end
			len = 1 + {$random(seed)} % 8;
			for (int k = 0; k < len; k++)
				random_read();
			cart_rd_i = 1'b0;
		end
	endtask

	task automatic run_download(input int size, input logic [7:0] index, input bit stress);
		logic [7:0] data;
		logic       err;
		int         waits;
		int         stores_before;
		stores_before = store_cnt;
		index_i = index;
		download_i = 1'b1;
		dl_busy = 1'b1;
		@(posedge clk_sys);
		#1;
		fork
			begin
				for (int i = 0; i < size; i++) begin
					data = 8'($random(seed));
					apb_xfer(1'b1, 14'(i), data, err, waits);
					check(32'd0, 32'(err), "download write error");
					model_mem[14'(i)] = data;
				end
				dl_busy = 1'b0;
			end
			begin
				if (stress)
					stall_reads();
			end
		join
		check(32'(size), 32'(store_cnt - stores_before), "memory writes per image");
		download_i = 1'b0;
		// Kind settles on the first edge after the fall
		repeat (2) begin
			@(posedge clk_sys);
			#1;
		end
		kind_model = classify(size, index == `VP_XROM_INDEX);
		$display("Image of %0d bytes loaded as %s", size, kind_model.name());
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Error response and clock enables
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_error_test();
		logic [11:0] a;
		logic        b0;
		logic        b1;
		logic [13:0] m;
		logic        err;
		int          waits;
		int          stores_before;
		a = 12'($random(seed));
		b0 = 1'($random(seed));
		b1 = 1'($random(seed));
		m = map_addr(kind_model, a, b0, b1);
		stores_before = store_cnt;
		apb_xfer(1'b1, m, ~model_mem[m], err, waits);
		check(32'd1, 32'(err), "write outside download error");
		check(32'd1, 32'(waits), "write outside download wait cycles");
		// APB reads are rejected too
		apb_xfer(1'b0, m, 8'h00, err, waits);
		check(32'd1, 32'(err), "apb read error");
		check(32'd1, 32'(waits), "apb read wait cycles");
		check(32'(stores_before), 32'(store_cnt), "memory writes outside download");
		issue_read(a, b0, b1);
		cart_rd_i = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_enables(input logic pal);
		int n_cpu;
		int n_vdc;
		int last_cpu;
		int last_vdc;
		int cpu_pulses;
		int vdc_pulses;
		n_cpu = pal ? `VP_CPU_DIV_PAL : `VP_CPU_DIV_NTSC;
		n_vdc = pal ? `VP_VDC_DIV_PAL : `VP_VDC_DIV_NTSC;
		last_cpu = 0;
		last_vdc = 0;
		cpu_pulses = 0;
		vdc_pulses = 0;
		pal_i = pal;
		download_i = 1'b1;
		repeat (4) begin
			@(posedge clk_sys);
			#1;
		end
		download_i = 1'b0;
		// Cycle c counts edges since the fall, first pulse gap is N too
		for (int c = 1; c <= 4 * n_cpu; c++) begin
			@(posedge clk_sys);
			#1;
			if (cpu_en_o) begin
				check(32'(n_cpu), 32'(c - last_cpu), "cpu enable gap");
				last_cpu = c;
				cpu_pulses++;
			end
			if (vdc_en_o) begin
				check(32'(n_vdc), 32'(c - last_vdc), "vdc enable gap");
				last_vdc = c;
				vdc_pulses++;
			end
		end
		check(32'd4, 32'(cpu_pulses), "cpu enable pulse count");
		check(32'((4 * n_cpu) / n_vdc), 32'(vdc_pulses), "vdc enable pulse count");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed = 42152;
		err_cnt = 0;
		check_cnt = 0;
		store_cnt = 0;
		dl_seen = 1'b0;
		dl_busy = 1'b0;
		kind_model = vp_cart_pkg::CART_2K;
		pal_i = 1'b0;
		download_i = 1'b0;
		index_i = 8'h00;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		cart_rd_i = 1'b0;
		cart_a_i = '0;
		cart_bs0_i = 1'b0;
		cart_bs1_i = 1'b0;

		wait (reset == 1'b0);
		#1;
		check(32'd0, 32'({pready_o, pslverr_o, rd_valid_o, cpu_en_o, vdc_en_o}),
			"outputs after reset");
		@(posedge clk_sys);
		#1;

		// Plain images of each size, then XROM
		run_download(2048, 8'd0, 1'b0);
		run_reads(NUM_READS);
		run_download(4096, 8'd0, 1'b0);
		run_reads(NUM_READS);
		run_download(8192, 8'd1, 1'b0);
		run_reads(NUM_READS);
		run_download(16384, 8'd3, 1'b0);
		run_reads(NUM_READS);
		run_download(4096, `VP_XROM_INDEX, 1'b0);
		run_reads(NUM_READS);

		// Download under console read pressure
		run_download(4096, 8'd5, 1'b1);
		run_reads(NUM_READS);

		apb_error_test();
		check_enables(1'b0);
		check_enables(1'b1);

		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/vp_cart_pkg.sv
verilog/vp_clk_enables.sv
verilog/vp_cart_loader.sv
verilog/vp_bank_map.sv
verilog/vp_rom_arbiter.sv
verilog/vp_cart_rom.sv
verilog/vp_cart_sys.sv
bench/tb_clk_gen.sv
bench/tb_vp_cart_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cartridge block testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_vp_cart_sys -f compile.f -o tb_vp_cart_sys
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_vp_cart_sys)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== verilog/vp_bank_map.sv ====
/* Console address and bank bits to cartridge memory address */
`default_nettype none
`include "vp_cart_cfg.svh"

module vp_bank_map (
	input  vp_cart_pkg::cart_kind_e     cart_kind_i,
	input  wire  [`VP_CART_AW-1:0]      cart_a_i,
	input  wire                         cart_bs0_i,
	input  wire                         cart_bs1_i,
	output logic [`VP_ROM_AW-1:0]       rd_addr_o
);

	// A10 selects internal RAM on the console, so most kinds drop it
	always_comb begin
		case (cart_kind_i)
			// Flat 4K window, bank bits ignored
			vp_cart_pkg::CART_XROM:
				rd_addr_o = `VP_ROM_AW'(cart_a_i);
			// Two 2K banks
			vp_cart_pkg::CART_4K:
				rd_addr_o = `VP_ROM_AW'({cart_bs0_i, cart_a_i[11], cart_a_i[9:0]});
			// Four 2K banks
			vp_cart_pkg::CART_8K:
				rd_addr_o = `VP_ROM_AW'({cart_bs1_i, cart_bs0_i, cart_a_i[11],
					cart_a_i[9:0]});
			// Four 4K banks, full console address
			vp_cart_pkg::CART_12K:
				rd_addr_o = `VP_ROM_AW'({cart_bs1_i, cart_bs0_i, cart_a_i[11:0]});
			// Plain 2K cartridge
			default:
				rd_addr_o = `VP_ROM_AW'({cart_a_i[11], cart_a_i[9:0]});
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/vp_cart_cfg.svh ====
/* Sizes, widths and divider ratios of the Videopac cartridge and timing block */
`ifndef VP_CART_CFG_SVH
`define VP_CART_CFG_SVH

// Cartridge memory, 16 KB of bytes
`define VP_ROM_AW 14
`define VP_DATA_W 8

// Console side program address
`define VP_CART_AW 12

// System cycles per CPU enable
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL 12

// System cycles per VDC enable
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL 10
`define VP_DIV_W 4

// Download index of an XROM image
`define VP_XROM_INDEX 8'd2

// Image byte counts that pick a bank mapping
`define VP_SIZE_4K 16'd4096
`define VP_SIZE_8K 16'd8192
`define VP_SIZE_16K 16'd16384

`endif

// ==== verilog/vp_cart_loader.sv ====
/* APB download port, image size counter and cartridge classification */
`default_nettype none
`include "vp_cart_cfg.svh"

module vp_cart_loader (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         download_i,
	input  wire  [7:0]                  index_i,
	input  wire                         psel_i,
	input  wire                         penable_i,
	input  wire                         pwrite_i,
	input  wire  [`VP_ROM_AW-1:0]       paddr_i,
	input  wire  [`VP_DATA_W-1:0]       pwdata_i,
	output logic                        pready_o,
	output logic                        pslverr_o,
	output logic                        wr_req_o,
	output logic [`VP_ROM_AW-1:0]       wr_addr_o,
	output logic [`VP_DATA_W-1:0]       wr_data_o,
	input  wire                         wr_gnt_i,
	output vp_cart_pkg::cart_kind_e     cart_kind_o
);

	logic                          access;
	logic                          wr_done;
	logic                          download_q;
	logic                          xrom_q;
	logic [15:0]                   byte_cnt;
	vp_cart_pkg::cart_kind_e       cart_kind_q;

	////////////////////////////////////////////////////////////////////////////
	// APB termination
	////////////////////////////////////////////////////////////////////////////

	// Access phase of any transfer
	assign access = psel_i & penable_i;

	// Only writes during a download reach memory
	assign wr_req_o  = access & pwrite_i & download_i;
	assign wr_addr_o = paddr_i;
	assign wr_data_o = pwdata_i;
	assign wr_done   = wr_req_o & wr_gnt_i;

	// Reads and stray writes finish at once with an error
	assign pslverr_o = access & (~pwrite_i | ~download_i);
	// Accepted writes wait for the memory grant
	assign pready_o  = pslverr_o | wr_done;

	////////////////////////////////////////////////////////////////////////////
	// Size count and classification
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
			xrom_q <= 1'b0;
			byte_cnt <= '0;
			cart_kind_q <= vp_cart_pkg::CART_2K;
		end else begin
			download_q <= download_i;

			// Download start, a byte stored on this same edge still counts
			if (download_i & ~download_q) begin
				byte_cnt <= wr_done ? 16'd1 : 16'd0;
				xrom_q <= (index_i == `VP_XROM_INDEX);
			end else if (wr_done) begin
				byte_cnt <= byte_cnt + 16'd1;
			end

			// Download end, size is final
			if (download_q & ~download_i) begin
				if (xrom_q)
					cart_kind_q <= vp_cart_pkg::CART_XROM;
				else if (byte_cnt == `VP_SIZE_4K)
					cart_kind_q <= vp_cart_pkg::CART_4K;
				else if (byte_cnt == `VP_SIZE_8K)
					cart_kind_q <= vp_cart_pkg::CART_8K;
				else if (byte_cnt == `VP_SIZE_16K)
					cart_kind_q <= vp_cart_pkg::CART_12K; // 16K image, banked as 12K
				else
					cart_kind_q <= vp_cart_pkg::CART_2K;
			end
		end
	end

	assign cart_kind_o = cart_kind_q;

endmodule

`default_nettype wire

// ==== verilog/vp_cart_pkg.sv ====
/* Cartridge kind and memory grant types */
`default_nettype none

package vp_cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Cartridge mapping schemes
	////////////////////////////////////////////////////////////////////////////

	// Picked from image size, XROM from the download index
	typedef enum logic [2:0] {
		CART_2K,
		CART_4K,
		CART_8K,
		CART_12K,
		CART_XROM
	} cart_kind_e;

	////////////////////////////////////////////////////////////////////////////
	// Shared memory port owner
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_READ,
		GNT_WRITE
	} arb_grant_e;

endpackage

`default_nettype wire

// ==== verilog/vp_cart_rom.sv ====
/* Single-port synchronous cartridge byte memory */
`default_nettype none
`include "vp_cart_cfg.svh"

module vp_cart_rom (
	input  wire                      clk_sys,
	input  wire                      en_i,
	input  wire                      we_i,
	input  wire  [`VP_ROM_AW-1:0]    addr_i,
	input  wire  [`VP_DATA_W-1:0]    wdata_i,
	output logic [`VP_DATA_W-1:0]    rdata_o
);

	// 16 KB image storage
	logic [`VP_DATA_W-1:0] mem [2**`VP_ROM_AW];

	// Read data holds its last value when idle or writing
	always_ff @(posedge clk_sys) begin
		if (en_i) begin
			if (we_i)
				mem[addr_i] <= wdata_i;
			else
				rdata_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/vp_cart_sys.sv ====
/* Videopac cartridge and timing block top level */
`default_nettype none

module vp_cart_sys (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         pal_i,
	input  wire         download_i,
	input  wire  [7:0]  index_i,
	input  wire         psel_i,
	input  wire         penable_i,
	input  wire         pwrite_i,
	input  wire  [13:0] paddr_i,
	input  wire  [7:0]  pwdata_i,
	output wire         pready_o,
	output wire         pslverr_o,
	input  wire         cart_rd_i,
	input  wire  [11:0] cart_a_i,
	input  wire         cart_bs0_i,
	input  wire         cart_bs1_i,
	output wire  [7:0]  cart_d_o,
	output wire         rd_valid_o,
	output wire         cpu_en_o,
	output wire         vdc_en_o
);

	// Download write path
	wire        wr_req;
	wire [13:0] wr_addr;
	wire [7:0]  wr_data;
	wire        wr_gnt;

	// Console read path
	vp_cart_pkg::cart_kind_e cart_kind;
	wire [13:0] rd_addr;

	// Memory port
	wire        mem_en;
	wire        mem_we;
	wire [13:0] mem_addr;
	wire [7:0]  mem_wdata;
	wire [7:0]  mem_rdata;

	////////////////////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////////////////////

	vp_clk_enables clk_enables_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_i      (pal_i),
		.download_i (download_i),
		.cpu_en_o   (cpu_en_o),
		.vdc_en_o   (vdc_en_o)
	);

	////////////////////////////////////////////////////////////////////////////
	// Cartridge
	////////////////////////////////////////////////////////////////////////////

	vp_cart_loader loader_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.download_i  (download_i),
		.index_i     (index_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.wr_req_o    (wr_req),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data),
		.wr_gnt_i    (wr_gnt),
		.cart_kind_o (cart_kind)
	);

	vp_bank_map bank_map_i (
		.cart_kind_i (cart_kind),
		.cart_a_i    (cart_a_i),
		.cart_bs0_i  (cart_bs0_i),
		.cart_bs1_i  (cart_bs1_i),
		.rd_addr_o   (rd_addr)
	);

	vp_rom_arbiter arbiter_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.rd_req_i    (cart_rd_i),
		.rd_addr_i   (rd_addr),
		.wr_req_i    (wr_req),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.wr_gnt_o    (wr_gnt),
		.mem_en_o    (mem_en),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_rdata_i (mem_rdata),
		.rd_data_o   (cart_d_o),
		.rd_valid_o  (rd_valid_o)
	);

	vp_cart_rom rom_i (
		.clk_sys (clk_sys),
		.en_i    (mem_en),
		.we_i    (mem_we),
		.addr_i  (mem_addr),
		.wdata_i (mem_wdata),
		.rdata_o (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/vp_clk_enables.sv ====
/* CPU and VDC clock-enable dividers, NTSC or PAL ratio */
`default_nettype none
`include "vp_cart_cfg.svh"

module vp_clk_enables (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  pal_i,
	input  wire  download_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Index 0 is the CPU divider, index 1 the VDC divider
	logic [`VP_DIV_W-1:0] div_cnt [2];
	logic [`VP_DIV_W-1:0] div_top [2];
	logic [1:0]           en_q;
	logic                 pal_q;
	logic                 hold;

	// Reload values, one less than the ratio
	assign div_top[0] = pal_i ? `VP_DIV_W'(`VP_CPU_DIV_PAL - 1) :
		`VP_DIV_W'(`VP_CPU_DIV_NTSC - 1);
	assign div_top[1] = pal_i ? `VP_DIV_W'(`VP_VDC_DIV_PAL - 1) :
		`VP_DIV_W'(`VP_VDC_DIV_NTSC - 1);

	// Standard change or download freezes both dividers
	assign hold = download_i | (pal_i != pal_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q <= 1'b0;
			en_q <= '0;
			for (int i = 0; i < 2; i++) begin
				div_cnt[i] <= '0;
			end
		end else begin
			pal_q <= pal_i;
			for (int i = 0; i < 2; i++) begin
				if (hold) begin
					div_cnt[i] <= '0;
					en_q[i] <= 1'b0;
				end else begin
					// Zero means freshly cleared or wrapped, restart the count
					if (div_cnt[i] == '0)
						div_cnt[i] <= div_top[i];
					else
						div_cnt[i] <= div_cnt[i] - 1'b1;
					// Pulse lands as the count leaves 1, N cycles after release
					en_q[i] <= (div_cnt[i] == `VP_DIV_W'(1));
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

`default_nettype wire

// ==== verilog/vp_rom_arbiter.sv ====
/* Read-priority arbiter for the shared cartridge memory */
`default_nettype none
`include "vp_cart_cfg.svh"

module vp_rom_arbiter (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      rd_req_i,
	input  wire  [`VP_ROM_AW-1:0]    rd_addr_i,
	input  wire                      wr_req_i,
	input  wire  [`VP_ROM_AW-1:0]    wr_addr_i,
	input  wire  [`VP_DATA_W-1:0]    wr_data_i,
	output logic                     wr_gnt_o,
	output logic                     mem_en_o,
	output logic                     mem_we_o,
	output logic [`VP_ROM_AW-1:0]    mem_addr_o,
	output logic [`VP_DATA_W-1:0]    mem_wdata_o,
	input  wire  [`VP_DATA_W-1:0]    mem_rdata_i,
	output logic [`VP_DATA_W-1:0]    rd_data_o,
	output logic                     rd_valid_o
);

	vp_cart_pkg::arb_grant_e grant;
	logic                    rd_valid_q;

	////////////////////////////////////////////////////////////////////////////
	// Grant, console read first
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (rd_req_i)
			grant = vp_cart_pkg::GNT_READ;
		else if (wr_req_i)
			grant = vp_cart_pkg::GNT_WRITE;
		else
			grant = vp_cart_pkg::GNT_IDLE;
	end

	// Download side stalls while the console reads
	assign wr_gnt_o = (grant == vp_cart_pkg::GNT_WRITE);

	// Memory port follows the grant
	assign mem_en_o    = (grant != vp_cart_pkg::GNT_IDLE);
	assign mem_we_o    = wr_gnt_o;
	assign mem_addr_o  = (grant == vp_cart_pkg::GNT_READ) ? rd_addr_i : wr_addr_i;
	assign mem_wdata_o = wr_data_i;

	////////////////////////////////////////////////////////////////////////////
	// Read return
	////////////////////////////////////////////////////////////////////////////

	// Memory answers one cycle after the read edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= (grant == vp_cart_pkg::GNT_READ);
	end

	assign rd_valid_o = rd_valid_q;
	assign rd_data_o  = mem_rdata_i;

endmodule

`default_nettype wire
